/* tb.f */
llc_pkg.sv
llc_input_decoder.sv
llc_localmem.sv
llc_bufs.sv
llc_lookup_way.sv
llc_process_request.sv
llc_core.sv
tb_llc_mem.sv
tb_llc_core.sv

/* tb_llc_core.sv */
/* Testbench for the LLC core
   Directed and random requests checked against a reference cache model */

`timescale 1ns/1ns

module tb_llc_core import llc_pkg::*; ();

    localparam int NUM_REQS = 350;

    logic           clk, rst;
    logic           req_valid_i, req_ready_o;
    llc_req_t       req_i;
    logic           rsp_valid_o, rsp_ready_i;
    llc_rsp_t       rsp_o;
    logic           mem_req_valid_o, mem_req_ready_i;
    llc_mem_req_t   mem_req_o;
    logic           mem_rsp_valid_i, mem_rsp_ready_o;
    llc_mem_rsp_t   mem_rsp_i;
    logic           rand_ready, mem_stall;

    integer         seed;
    int             errors, test_base, tests, failed_tests;
    string          cur_test;

    // Reference model state
    llc_line_state_e        m_state [LLC_SETS][LLC_WAYS];
    logic [TAG_BITS-1:0]    m_tag   [LLC_SETS][LLC_WAYS];
    logic [LINE_BITS-1:0]   m_line  [LLC_SETS][LLC_WAYS];
    logic [WAY_BITS-1:0]    m_ptr   [LLC_SETS];
    logic [LINE_BITS-1:0]   shadow  [1 << ADDR_BITS];
    llc_mem_req_t           exp_mem_q [$];
    logic [LINE_BITS-1:0]   exp_rsp_q [$];
    llc_mem_req_t           mem_exp;

    llc_core i_dut (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_o           (rsp_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_ready_o (mem_rsp_ready_o)
    );

    tb_llc_mem mem_model_u (
        .clk             (clk),
        .stall_en_i      (mem_stall),
        .mem_req_valid_i (mem_req_valid_o),
        .mem_req_i       (mem_req_o),
        .mem_req_ready_o (mem_req_ready_i),
        .mem_rsp_valid_o (mem_rsp_valid_i),
        .mem_rsp_o       (mem_rsp_i),
        .mem_rsp_ready_i (mem_rsp_ready_o)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("** Error: %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic init_model();
        for (int s = 0; s < LLC_SETS; s++) begin
            m_ptr[s] = '0;
            for (int w = 0; w < LLC_WAYS; w++)
                m_state[s][w] = ST_INVALID;
        end
        for (int a = 0; a < (1 << ADDR_BITS); a++)
            shadow[a] = LINE_BITS'(a) ^ 32'hA5A5_0000;
    endtask

    // Write-back, write-allocate model with per-set round-robin victims
    function automatic logic [LINE_BITS-1:0] model_access(input llc_req_t req,
                                                          output logic miss);
        logic [SET_BITS-1:0]    s;
        logic [TAG_BITS-1:0]    t;
        int                     way;
        llc_mem_req_t           mr;
        s   = req.addr[SET_BITS-1:0];
        t   = req.addr[ADDR_BITS-1:SET_BITS];
        way = -1;
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (m_state[s][w] != ST_INVALID && m_tag[s][w] == t)
                way = w;
        end
        miss = (way < 0);
        if (miss) begin
            way = m_ptr[s];
            m_ptr[s] = m_ptr[s] + 1'b1;
            if (m_state[s][way] == ST_DIRTY) begin
                mr = '{op: OP_WRITE, addr: {m_tag[s][way], s}, data: m_line[s][way]};
                exp_mem_q.push_back(mr);
                shadow[mr.addr] = mr.data;
            end
            if (req.op == OP_READ) begin
                mr = '{op: OP_READ, addr: req.addr, data: '0};
                exp_mem_q.push_back(mr);
                m_line[s][way] = shadow[req.addr];
            end
        end
        if (req.op == OP_WRITE)
            m_line[s][way] = req.data;
        m_state[s][way] = (req.op == OP_WRITE) ? ST_DIRTY : ST_VALID;
        m_tag[s][way]   = t;
        return m_line[s][way];
    endfunction

    task automatic run_request(input llc_op_e op, input logic [ADDR_BITS-1:0] addr,
                               input logic [LINE_BITS-1:0] data);
        llc_req_t               req;
        logic                   miss;
        int                     lat, first_lat;
        logic                   got;
        integer                 rnd;
        req = '{op: op, addr: addr, data: data};
        exp_rsp_q.push_back(model_access(req, miss));
        @(posedge clk);
        #5;
        req_valid_i = 1'b1;
        req_i       = req;
        @(negedge clk);
        while (!req_ready_o)
            @(negedge clk);
        @(posedge clk);
        #5;
        req_valid_i = 1'b0;
        lat       = 0;
        first_lat = 0;
        got       = 1'b0;
        while (!got) begin
            @(posedge clk);
            lat++;
            #5;
            rnd = $random(seed);
            rsp_ready_i = rand_ready ? rnd[0] : 1'b1;
            @(negedge clk);
            if (rsp_valid_o && first_lat == 0)
                first_lat = lat;
            if (rsp_valid_o && rsp_ready_i)
                got = 1'b1;
        end
        if (!miss)
            check_value({cur_test, " hit latency"}, 4, first_lat);
    endtask

    // Sets 1, 9 and 14 with tags 0x30..0x39
    task automatic run_random(input int count);
        int                     sel;
        logic [SET_BITS-1:0]    s;
        logic [TAG_BITS-1:0]    t;
        integer                 r;
        for (int i = 0; i < count; i++) begin
            sel = $unsigned($random(seed)) % 3;
            s   = (sel == 0) ? 4'd1 : ((sel == 1) ? 4'd9 : 4'd14);
            t   = 8'h30 + TAG_BITS'($unsigned($random(seed)) % 10);
            r   = $random(seed);
            run_request(r[0] ? OP_WRITE : OP_READ, {t, s}, $random(seed));
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_base = errors;
    endtask

    task automatic finish_test();
        int n;
        // Last response transfers on this edge
        @(posedge clk);
        if (exp_mem_q.size() != 0) begin
            $display("%s: %0d expected memory requests were never issued",
                     cur_test, exp_mem_q.size());
            errors++;
            exp_mem_q.delete();
        end
        if (exp_rsp_q.size() != 0) begin
            $display("%s: %0d responses never arrived", cur_test, exp_rsp_q.size());
            errors++;
            exp_rsp_q.delete();
        end
        n = errors - test_base;
        tests++;
        if (n != 0)
            failed_tests++;
        $display("Test %-18s %s, %0d errors", cur_test, (n == 0) ? "ok" : "failed", n);
    endtask

    // Compares memory traffic and responses as they transfer
    always @(negedge clk) begin
        if (rst && mem_req_valid_o && mem_req_ready_i) begin
            if (exp_mem_q.size() == 0) begin
                $display("%s: unexpected memory request to address %h",
                         cur_test, mem_req_o.addr);
                errors++;
            end else begin
                mem_exp = exp_mem_q.pop_front();
                check_value({cur_test, " mem op"}, mem_exp.op, mem_req_o.op);
                check_value({cur_test, " mem addr"}, mem_exp.addr, mem_req_o.addr);
                if (mem_exp.op == OP_WRITE)
                    check_value({cur_test, " mem data"}, mem_exp.data, mem_req_o.data);
            end
        end
        if (rst && rsp_valid_o && rsp_ready_i) begin
            if (exp_rsp_q.size() == 0) begin
                $display("%s: response arrived with no request outstanding", cur_test);
                errors++;
            end else begin
                check_value({cur_test, " rsp data"}, exp_rsp_q.pop_front(), rsp_o.data);
            end
        end
    end

    initial begin
        repeat (NUM_REQS * 200 + 1000) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", NUM_REQS * 200 + 1000);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        rsp_ready_i  = 1'b1;
        rand_ready   = 1'b0;
        mem_stall    = 1'b0;
        seed         = 32'h244a_c32c;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        cur_test     = "reset";
        init_model();
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b1;

        start_test("reset_outputs");
        @(negedge clk);
        check_value("reset_outputs req_ready", 0, req_ready_o);
        check_value("reset_outputs rsp_valid", 0, rsp_valid_o);
        check_value("reset_outputs mem_req_valid", 0, mem_req_valid_o);
        check_value("reset_outputs mem_rsp_ready", 0, mem_rsp_ready_o);
        finish_test();

        start_test("first_read_miss");
        run_request(OP_READ, 12'h123, '0);
        finish_test();

        start_test("repeat_read_hit");
        run_request(OP_READ, 12'h123, '0);
        finish_test();

        start_test("write_then_read");
        run_request(OP_WRITE, 12'h456, 32'hCAFE_0456);
        run_request(OP_READ, 12'h456, '0);
        finish_test();

        // Set 7 takes a dirty victim first and then a clean one
        start_test("round_robin_evict");
        run_request(OP_WRITE, 12'h107, 32'h1111_0107);
        run_request(OP_READ, 12'h117, '0);
        run_request(OP_WRITE, 12'h127, 32'h3333_0127);
        run_request(OP_READ, 12'h137, '0);
        run_request(OP_READ, 12'h147, '0);
        run_request(OP_READ, 12'h157, '0);
        finish_test();

        start_test("backpressure");
        rand_ready = 1'b1;
        mem_stall  = 1'b1;
        run_random(40);
        rand_ready = 1'b0;
        mem_stall  = 1'b0;
        finish_test();

        start_test("random_traffic");
        run_random(300);
        finish_test();

        $display("Summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* tb_llc_mem.sv */
/* Main memory model for the LLC testbench
   Answers fills after a random delay and randomly drops request ready */

`timescale 1ns/1ns

module tb_llc_mem import llc_pkg::*; (
    input  logic            clk,
    input  logic            stall_en_i,
    input  logic            mem_req_valid_i,
    input  llc_mem_req_t    mem_req_i,
    output logic            mem_req_ready_o,
    output logic            mem_rsp_valid_o,
    output llc_mem_rsp_t    mem_rsp_o,
    input  logic            mem_rsp_ready_i
);

    logic [LINE_BITS-1:0]   mem [1 << ADDR_BITS];
    integer                 seed;
    integer                 r;
    int                     delay;
    logic                   pending, req_take, rsp_take;
    llc_mem_req_t           req_q;
    logic [ADDR_BITS-1:0]   rd_addr;

    initial begin
        seed = 32'h244a_c32c;
        for (int a = 0; a < (1 << ADDR_BITS); a++) begin
            mem[a] = LINE_BITS'(a) ^ 32'hA5A5_0000;
        end
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_o       = '0;
        pending         = 1'b0;
        delay           = 0;
        rd_addr         = '0;
        forever begin
            // Handshakes resolved on stable values before the edge
            @(negedge clk);
            req_take = mem_req_valid_i && mem_req_ready_o;
            rsp_take = mem_rsp_valid_o && mem_rsp_ready_i;
            req_q    = mem_req_i;
            @(posedge clk);
            #5;
            if (rsp_take)
                mem_rsp_valid_o = 1'b0;
            if (req_take && req_q.op == OP_WRITE) begin
                mem[req_q.addr] = req_q.data;
            end else if (req_take) begin
                r       = $random(seed);
                delay   = 1 + ($unsigned(r) % 5);
                rd_addr = req_q.addr;
                pending = 1'b1;
            end else if (pending) begin
                delay = delay - 1;
                if (delay == 0) begin
                    mem_rsp_valid_o = 1'b1;
                    mem_rsp_o.data  = mem[rd_addr];
                    pending         = 1'b0;
                end
            end
            r = $random(seed);
            mem_req_ready_o = stall_en_i ? r[0] : 1'b1;
        end
    end

endmodule

/* llc_core.sv */
/* LLC core top level
   Phase-sequenced write-back cache; owns the phase FSM and the reset flush */

`timescale 1ns/1ns

module llc_core import llc_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid_i,
    input  llc_req_t        req_i,
    output logic            req_ready_o,
    output logic            rsp_valid_o,
    output llc_rsp_t        rsp_o,
    input  logic            rsp_ready_i,
    output logic            mem_req_valid_o,
    output llc_mem_req_t    mem_req_o,
    input  logic            mem_req_ready_i,
    input  logic            mem_rsp_valid_i,
    input  llc_mem_rsp_t    mem_rsp_i,
    output logic            mem_rsp_ready_o
);

    llc_phase_e                     phase, phase_next;
    logic [SET_BITS-1:0]            flush_set;

    logic                           decode_en, rd_en, load_en;
    logic                           lookup_en, process_en, update_en;
    logic                           process_done, rsp_pending;

    llc_req_t                       req_q;
    logic [SET_BITS-1:0]            set;
    logic [TAG_BITS-1:0]            tag;

    llc_way_entry_t [LLC_WAYS-1:0]  rd_ways, buf_ways;
    logic [WAY_BITS-1:0]            rd_evict_way, buf_evict_way;
    logic                           hit;
    logic [WAY_BITS-1:0]            way;

    logic                           proc_wr_en;
    logic [SET_BITS-1:0]            proc_wr_set;
    logic [WAY_BITS-1:0]            proc_wr_way;
    llc_way_entry_t                 proc_wr_entry;
    logic [WAY_BITS-1:0]            proc_wr_evict_way;

    logic                           lm_wr_en, lm_clr_all;
    logic [SET_BITS-1:0]            lm_wr_set;
    logic [WAY_BITS-1:0]            lm_wr_evict_way;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase     <= PH_RESET;
            flush_set <= '0;
        end else begin
            phase <= phase_next;
            if (phase == PH_RESET)
                flush_set <= flush_set + 1'b1;
        end
    end

    always_comb begin
        phase_next = phase;
        case (phase)
            PH_RESET:    if (flush_set == SET_BITS'(LLC_SETS - 1)) phase_next = PH_DECODE;
            PH_DECODE:   if (req_valid_i && req_ready_o) phase_next = PH_READ_SET;
            PH_READ_SET: phase_next = PH_LOOKUP;
            PH_LOOKUP:   phase_next = PH_PROCESS;
            PH_PROCESS:  if (process_done) phase_next = PH_UPDATE;
            PH_UPDATE:   phase_next = PH_DECODE;
            default:     phase_next = PH_RESET;
        endcase
    end

    assign decode_en  = (phase == PH_DECODE);
    assign load_en    = (phase == PH_READ_SET);
    assign lookup_en  = (phase == PH_LOOKUP);
    assign process_en = (phase == PH_PROCESS);
    assign update_en  = (phase == PH_UPDATE);

    // Set read issued in the accepting cycle
    assign rd_en = decode_en && req_valid_i && req_ready_o;

    // Flush owns the write port until decode starts
    assign lm_wr_en        = (phase == PH_RESET) ? 1'b1 : proc_wr_en;
    assign lm_clr_all      = (phase == PH_RESET);
    assign lm_wr_set       = (phase == PH_RESET) ? flush_set : proc_wr_set;
    assign lm_wr_evict_way = (phase == PH_RESET) ? '0 : proc_wr_evict_way;

    llc_input_decoder input_decoder_u (
        .clk            (clk),
        .rst            (rst),
        .decode_en_i    (decode_en),
        .rsp_pending_i  (rsp_pending),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .req_ready_o    (req_ready_o),
        .req_o          (req_q),
        .set_o          (set),
        .tag_o          (tag)
    );

    llc_localmem localmem_u (
        .clk            (clk),
        .rd_en_i        (rd_en),
        .rd_set_i       (set),
        .rd_ways_o      (rd_ways),
        .rd_evict_way_o (rd_evict_way),
        .wr_en_i        (lm_wr_en),
        .wr_set_i       (lm_wr_set),
        .wr_way_i       (proc_wr_way),
        .wr_entry_i     (proc_wr_entry),
        .wr_evict_way_i (lm_wr_evict_way),
        .clr_all_way_i  (lm_clr_all)
    );

    llc_bufs bufs_u (
        .clk            (clk),
        .rst            (rst),
        .load_i         (load_en),
        .ways_i         (rd_ways),
        .evict_way_i    (rd_evict_way),
        .ways_o         (buf_ways),
        .evict_way_o    (buf_evict_way)
    );

    llc_lookup_way lookup_way_u (
        .clk            (clk),
        .rst            (rst),
        .lookup_en_i    (lookup_en),
        .tag_i          (tag),
        .ways_i         (buf_ways),
        .evict_way_i    (buf_evict_way),
        .hit_o          (hit),
        .way_o          (way)
    );

    llc_process_request process_request_u (
        .clk             (clk),
        .rst             (rst),
        .process_en_i    (process_en),
        .update_en_i     (update_en),
        .req_i           (req_q),
        .set_i           (set),
        .hit_i           (hit),
        .way_i           (way),
        .ways_i          (buf_ways),
        .evict_way_i     (buf_evict_way),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .process_done_o  (process_done),
        .wr_en_o         (proc_wr_en),
        .wr_set_o        (proc_wr_set),
        .wr_way_o        (proc_wr_way),
        .wr_entry_o      (proc_wr_entry),
        .wr_evict_way_o  (proc_wr_evict_way),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_o           (rsp_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_pending_o   (rsp_pending)
    );

endmodule

/* llc_process_request.sv */
/* LLC request processor
   Hit/miss handling with write-back and fill traffic, array update and response */

`timescale 1ns/1ns

module llc_process_request import llc_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            process_en_i,
    input  logic                            update_en_i,
    input  llc_req_t                        req_i,
    input  logic [SET_BITS-1:0]             set_i,
    input  logic                            hit_i,
    input  logic [WAY_BITS-1:0]             way_i,
    input  llc_way_entry_t [LLC_WAYS-1:0]   ways_i,
    input  logic [WAY_BITS-1:0]             evict_way_i,
    output logic                            mem_req_valid_o,
    output llc_mem_req_t                    mem_req_o,
    input  logic                            mem_req_ready_i,
    input  logic                            mem_rsp_valid_i,
    input  llc_mem_rsp_t                    mem_rsp_i,
    output logic                            mem_rsp_ready_o,
    output logic                            process_done_o,
    output logic                            wr_en_o,
    output logic [SET_BITS-1:0]             wr_set_o,
    output logic [WAY_BITS-1:0]             wr_way_o,
    output llc_way_entry_t                  wr_entry_o,
    output logic [WAY_BITS-1:0]             wr_evict_way_o,
    output logic                            rsp_valid_o,
    output llc_rsp_t                        rsp_o,
    input  logic                            rsp_ready_i,
    output logic                            rsp_pending_o
);

    typedef enum logic [1:0] {
        PS_IDLE,
        PS_WRITEBACK,
        PS_FILL_REQ,
        PS_FILL_WAIT
    } proc_state_e;

    proc_state_e            state, state_next;
    llc_way_entry_t         cur_entry;
    logic                   is_write, cur_dirty;
    logic [LINE_BITS-1:0]   fill_line, new_line;

    // Hit way on a hit, pointer victim on a miss
    assign cur_entry = ways_i[way_i];
    assign is_write  = (req_i.op == OP_WRITE);
    assign cur_dirty = (cur_entry.state == ST_DIRTY);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= PS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next      = state;
        process_done_o  = 1'b0;
        mem_req_valid_o = 1'b0;
        mem_req_o       = '0;
        mem_rsp_ready_o = 1'b0;
        case (state)
            PS_IDLE: begin
                if (process_en_i) begin
                    if (hit_i || (is_write && !cur_dirty)) begin
                        process_done_o = 1'b1;
                    end else if (cur_dirty) begin
                        state_next = PS_WRITEBACK;
                    end else begin
                        state_next = PS_FILL_REQ;
                    end
                end
            end
            PS_WRITEBACK: begin
                mem_req_valid_o = 1'b1;
                mem_req_o = '{op: OP_WRITE, addr: {cur_entry.tag, set_i}, data: cur_entry.line};
                if (mem_req_ready_i) begin
                    if (is_write) begin
                        process_done_o = 1'b1;
                        state_next     = PS_IDLE;
                    end else begin
                        state_next = PS_FILL_REQ;
                    end
                end
            end
            PS_FILL_REQ: begin
                mem_req_valid_o = 1'b1;
                mem_req_o = '{op: OP_READ, addr: req_i.addr, data: '0};
                if (mem_req_ready_i)
                    state_next = PS_FILL_WAIT;
            end
            PS_FILL_WAIT: begin
                mem_rsp_ready_o = 1'b1;
                if (mem_rsp_valid_i) begin
                    process_done_o = 1'b1;
                    state_next     = PS_IDLE;
                end
            end
            default: state_next = PS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == PS_FILL_WAIT && mem_rsp_valid_i) begin
            fill_line <= mem_rsp_i.data;
        end
    end

    assign new_line = is_write ? req_i.data : (hit_i ? cur_entry.line : fill_line);

    // Array write during the update phase
    assign wr_en_o    = update_en_i;
    assign wr_set_o   = set_i;
    assign wr_way_o   = way_i;
    assign wr_entry_o = '{state: is_write ? ST_DIRTY : ST_VALID,
                          tag:   req_i.addr[ADDR_BITS-1:SET_BITS],
                          line:  new_line};
    // Pointer moves only on a miss
    assign wr_evict_way_o = hit_i ? evict_way_i : evict_way_i + 1'b1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_valid_o <= 1'b0;
        end else if (update_en_i) begin
            rsp_valid_o <= 1'b1;
        end else if (rsp_valid_o && rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (update_en_i) begin
            rsp_o.data <= new_line;
        end
    end

    assign rsp_pending_o = rsp_valid_o;

endmodule

/* llc_lookup_way.sv */
/* LLC way lookup
   Tag match over the buffered set, falling back to the round-robin victim */

`timescale 1ns/1ns

module llc_lookup_way import llc_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            lookup_en_i,
    input  logic [TAG_BITS-1:0]             tag_i,
    input  llc_way_entry_t [LLC_WAYS-1:0]   ways_i,
    input  logic [WAY_BITS-1:0]             evict_way_i,
    output logic                            hit_o,
    output logic [WAY_BITS-1:0]             way_o
);

    logic                   hit_c;
    logic [WAY_BITS-1:0]    hit_way_c;

    always_comb begin
        hit_c     = 1'b0;
        hit_way_c = '0;
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (ways_i[w].state != ST_INVALID && ways_i[w].tag == tag_i) begin
                hit_c     = 1'b1;
                hit_way_c = WAY_BITS'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_o <= 1'b0;
            way_o <= '0;
        end else if (lookup_en_i) begin
            hit_o <= hit_c;
            way_o <= hit_c ? hit_way_c : evict_way_i;
        end
    end

endmodule

/* llc_bufs.sv */
/* LLC set buffers
   Holds the current set's ways and eviction pointer for lookup and processing */

`timescale 1ns/1ns

module llc_bufs import llc_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load_i,
    input  llc_way_entry_t [LLC_WAYS-1:0]   ways_i,
    input  logic [WAY_BITS-1:0]             evict_way_i,
    output llc_way_entry_t [LLC_WAYS-1:0]   ways_o,
    output logic [WAY_BITS-1:0]             evict_way_o
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            evict_way_o <= '0;
        end else if (load_i) begin
            evict_way_o <= evict_way_i;
        end
    end

    // Copy of the set so the arrays are free for the update write
    always_ff @(posedge clk) begin
        if (load_i) begin
            ways_o <= ways_i;
        end
    end

endmodule

/* llc_localmem.sv */
/* LLC local arrays
   Per-set way entries and round-robin pointers with registered read */

`timescale 1ns/1ns

module llc_localmem import llc_pkg::*; (
    input  logic                            clk,
    input  logic                            rd_en_i,
    input  logic [SET_BITS-1:0]             rd_set_i,
    output llc_way_entry_t [LLC_WAYS-1:0]   rd_ways_o,
    output logic [WAY_BITS-1:0]             rd_evict_way_o,
    input  logic                            wr_en_i,
    input  logic [SET_BITS-1:0]             wr_set_i,
    input  logic [WAY_BITS-1:0]             wr_way_i,
    input  llc_way_entry_t                  wr_entry_i,
    input  logic [WAY_BITS-1:0]             wr_evict_way_i,
    input  logic                            clr_all_way_i
);

    llc_way_entry_t [LLC_WAYS-1:0]  set_mem   [LLC_SETS];
    logic [WAY_BITS-1:0]            evict_mem [LLC_SETS];

    // Whole set in one read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_ways_o      <= set_mem[rd_set_i];
            rd_evict_way_o <= evict_mem[rd_set_i];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            if (clr_all_way_i) begin
                for (int w = 0; w < LLC_WAYS; w++) begin
                    set_mem[wr_set_i][w] <= '{state: ST_INVALID, tag: '0, line: '0};
                end
            end else begin
                set_mem[wr_set_i][wr_way_i] <= wr_entry_i;
            end
            evict_mem[wr_set_i] <= wr_evict_way_i;
        end
    end

endmodule

/* llc_input_decoder.sv */
/* LLC input decoder
   Accepts one request per decode phase and splits its line address */

`timescale 1ns/1ns

module llc_input_decoder import llc_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                decode_en_i,
    input  logic                rsp_pending_i,
    input  logic                req_valid_i,
    input  llc_req_t            req_i,
    output logic                req_ready_o,
    output llc_req_t            req_o,
    output logic [SET_BITS-1:0] set_o,
    output logic [TAG_BITS-1:0] tag_o
);

    logic accept;

    // No new request while the previous response waits
    assign req_ready_o = decode_en_i && !rsp_pending_i;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_o <= '0;
        end else if (accept) begin
            req_o <= req_i;
        end
    end

    // Incoming set feeds the array read during decode
    assign set_o = decode_en_i ? req_i.addr[SET_BITS-1:0] : req_o.addr[SET_BITS-1:0];
    assign tag_o = req_o.addr[ADDR_BITS-1:SET_BITS];

endmodule

/* llc_pkg.sv */
/* LLC shared definitions
   Cache geometry, enums and channel structs for the last-level cache core */

package llc_pkg;

    // 16 sets of 4 ways with one 32-bit word per line
    localparam int LLC_SETS  = 16;
    localparam int LLC_WAYS  = 4;
    localparam int SET_BITS  = 4;
    localparam int WAY_BITS  = 2;
    localparam int TAG_BITS  = 8;
    localparam int ADDR_BITS = 12;
    localparam int LINE_BITS = 32;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } llc_op_e;

    typedef enum logic [1:0] {
        ST_INVALID,
        ST_VALID,
        ST_DIRTY
    } llc_line_state_e;

    typedef enum logic [2:0] {
        PH_RESET,
        PH_DECODE,
        PH_READ_SET,
        PH_LOOKUP,
        PH_PROCESS,
        PH_UPDATE
    } llc_phase_e;

    // Requester channels
    typedef struct packed {
        llc_op_e                op;
        logic [ADDR_BITS-1:0]   addr;
        logic [LINE_BITS-1:0]   data;
    } llc_req_t;

    typedef struct packed {
        logic [LINE_BITS-1:0]   data;
    } llc_rsp_t;

    // Main memory channels
    typedef struct packed {
        llc_op_e                op;
        logic [ADDR_BITS-1:0]   addr;
        logic [LINE_BITS-1:0]   data;
    } llc_mem_req_t;

    typedef struct packed {
        logic [LINE_BITS-1:0]   data;
    } llc_mem_rsp_t;

    // Contents of one way
    typedef struct packed {
        llc_line_state_e        state;
        logic [TAG_BITS-1:0]    tag;
        logic [LINE_BITS-1:0]   line;
    } llc_way_entry_t;

endpackage
